// ==== verilog/div_consts.svh ====
/* Divide unit constants */

`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// Dividend width in bits.
`define DIV_DIVIDEND_W 32

// Divisor width, which is also the quotient and remainder width.
`define DIV_DIVISOR_W 16

// Quotient bits retired per pipeline stage (radix 4).
`define DIV_DIGIT_W 2

// Number of digit stages, quotient width over digit width.
`define DIV_STAGES 8

`endif

// ==== verilog/div_pkg.sv ====
/* Divide unit types */

`include "div_consts.svh"

package div_pkg;

	typedef logic [`DIV_DIVIDEND_W-1:0] dividend_t;
	typedef logic [`DIV_DIVISOR_W-1:0]  divisor_t;
	typedef logic [`DIV_DIVISOR_W-1:0]  quotient_t;
	typedef logic [`DIV_DIVISOR_W-1:0]  remainder_t;
	typedef logic [`DIV_DIVIDEND_W-1:0] partial_t;  // Remainder on top, quotient below.

	typedef enum logic [1:0] {
		DIV_OK       = 2'd0,
		DIV_ZERO     = 2'd1,
		DIV_OVERFLOW = 2'd2
	} div_status_t;

	typedef struct packed {
		dividend_t dividend;
		divisor_t  divisor;
		logic      is_signed;
	} div_req_t;

	// Operation word carried down the pipeline.
	typedef struct packed {
		partial_t    partial;
		divisor_t    divisor;      // Divisor magnitude.
		remainder_t  dividend_lo;  // Raw low half, the remainder for a zero divisor.
		logic        neg_quot;
		logic        neg_rem;
		logic        is_signed;
		div_status_t status;
	} div_op_t;

	typedef struct packed {
		quotient_t   quotient;
		remainder_t  remainder;
		div_status_t status;
	} div_rsp_t;

endpackage

// ==== verilog/div_decode.sv ====
/* Divide operand decode */

`timescale 1ns/1ns
`include "div_consts.svh"

module div_decode (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              advance,
	input  logic              in_valid,
	input  div_pkg::div_req_t in_req,
	output logic              op_valid,
	output div_pkg::div_op_t  op
);

	logic               dvd_neg;
	logic               dvs_neg;
	div_pkg::dividend_t dvd_mag;
	div_pkg::divisor_t  dvs_mag;
	div_pkg::div_op_t   op_next;

	// Signs only count in signed mode.
	assign dvd_neg = in_req.is_signed & in_req.dividend[`DIV_DIVIDEND_W-1];
	assign dvs_neg = in_req.is_signed & in_req.divisor[`DIV_DIVISOR_W-1];

	// The most negative values map to their unsigned magnitude.
	assign dvd_mag = dvd_neg ? -in_req.dividend : in_req.dividend;
	assign dvs_mag = dvs_neg ? -in_req.divisor : in_req.divisor;

	always_comb begin
		op_next.partial     = dvd_mag;
		op_next.divisor     = dvs_mag;
		op_next.dividend_lo = in_req.dividend[`DIV_DIVISOR_W-1:0];
		op_next.neg_quot    = dvd_neg ^ dvs_neg;
		op_next.neg_rem     = dvd_neg;  // Remainder follows the dividend.
		op_next.is_signed   = in_req.is_signed;
		// A quotient fits in 16 bits only if the upper half is below the divisor.
		if (in_req.divisor == '0)
			op_next.status = div_pkg::DIV_ZERO;
		else if (dvd_mag[`DIV_DIVIDEND_W-1 -: `DIV_DIVISOR_W] >= dvs_mag)
			op_next.status = div_pkg::DIV_OVERFLOW;
		else
			op_next.status = div_pkg::DIV_OK;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			op_valid <= 1'b0;
		else if (advance)
			op_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (advance)
			op <= op_next;
	end

endmodule

// ==== verilog/div_digit_stage.sv ====
/* Radix-4 divide stage */

`timescale 1ns/1ns
`include "div_consts.svh"

module div_digit_stage (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             advance,
	input  logic             in_valid,
	input  div_pkg::div_op_t in_op,
	output logic             out_valid,
	output div_pkg::div_op_t out_op
);

	localparam int TRIAL_W = `DIV_DIVISOR_W + `DIV_DIGIT_W;

	logic [TRIAL_W-1:0]      trial;
	logic [TRIAL_W-1:0]      dvs_x1;
	logic [TRIAL_W-1:0]      dvs_x2;
	logic [TRIAL_W-1:0]      dvs_x3;
	logic [TRIAL_W-1:0]      diff;
	logic [`DIV_DIGIT_W-1:0] digit;
	div_pkg::div_op_t        op_next;

	// Running remainder with the next two dividend bits shifted in.
	assign trial  = in_op.partial[`DIV_DIVIDEND_W-1 -: TRIAL_W];
	assign dvs_x1 = {{`DIV_DIGIT_W{1'b0}}, in_op.divisor};
	assign dvs_x2 = dvs_x1 << 1;
	assign dvs_x3 = dvs_x1 + dvs_x2;

	always_comb begin
		// Largest multiple of the divisor that still fits picks the digit.
		if (trial >= dvs_x3) begin
			digit = 2'd3;
			diff  = trial - dvs_x3;
		end else if (trial >= dvs_x2) begin
			digit = 2'd2;
			diff  = trial - dvs_x2;
		end else if (trial >= dvs_x1) begin
			digit = 2'd1;
			diff  = trial - dvs_x1;
		end else begin
			digit = 2'd0;
			diff  = trial;
		end
	end

	always_comb begin
		op_next         = in_op;
		op_next.partial = {diff[`DIV_DIVISOR_W-1:0],
			in_op.partial[`DIV_DIVIDEND_W-TRIAL_W-1:0], digit};
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (advance)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (advance)
			out_op <= op_next;
	end

endmodule

// ==== verilog/div_execute.sv ====
/* Radix-4 divide stage chain */

`timescale 1ns/1ns
`include "div_consts.svh"

module div_execute (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             advance,
	input  logic             in_valid,
	input  div_pkg::div_op_t in_op,
	output logic             out_valid,
	output div_pkg::div_op_t out_op
);

	// Index 0 is the chain input, index DIV_STAGES the last stage output.
	div_pkg::div_op_t     stage_op [0:`DIV_STAGES];
	logic [`DIV_STAGES:0] stage_valid;

	assign stage_op[0]    = in_op;
	assign stage_valid[0] = in_valid;

	// Each stage retires two quotient bits, most significant first.
	for (genvar i = 0; i < `DIV_STAGES; i++) begin : g_stage
		div_digit_stage u_stage (
			.clk       (clk),
			.rst_n     (rst_n),
			.advance   (advance),
			.in_valid  (stage_valid[i]),
			.in_op     (stage_op[i]),
			.out_valid (stage_valid[i+1]),
			.out_op    (stage_op[i+1])
		);
	end

	// The final word holds the unsigned remainder over the unsigned quotient.
	assign out_valid = stage_valid[`DIV_STAGES];
	assign out_op    = stage_op[`DIV_STAGES];

endmodule

// ==== verilog/div_result.sv ====
/* Divide result and output register */

`timescale 1ns/1ns
`include "div_consts.svh"

module div_result (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  div_pkg::div_op_t  in_op,
	output logic              advance,
	output logic              out_valid,
	input  logic              out_ready,
	output div_pkg::div_rsp_t out_rsp
);

	// Largest quotient magnitudes in the signed range.
	localparam div_pkg::quotient_t QUOT_POS_MAX = {1'b0, {(`DIV_DIVISOR_W-1){1'b1}}};
	localparam div_pkg::quotient_t QUOT_NEG_MAX = {1'b1, {(`DIV_DIVISOR_W-1){1'b0}}};

	div_pkg::quotient_t   q_mag;
	div_pkg::remainder_t  r_mag;
	div_pkg::quotient_t   q_fixed;
	div_pkg::remainder_t  r_fixed;
	logic                 range_err;
	div_pkg::div_status_t status;
	div_pkg::div_rsp_t    rsp_next;

	assign q_mag   = in_op.partial[`DIV_DIVISOR_W-1:0];
	assign r_mag   = in_op.partial[`DIV_DIVIDEND_W-1 -: `DIV_DIVISOR_W];
	assign q_fixed = in_op.neg_quot ? -q_mag : q_mag;
	assign r_fixed = in_op.neg_rem ? -r_mag : r_mag;

	assign range_err = in_op.is_signed &&
		(in_op.neg_quot ? (q_mag > QUOT_NEG_MAX) : (q_mag > QUOT_POS_MAX));

	// Earlier exceptions take priority over the signed range check.
	assign status = (in_op.status == div_pkg::DIV_OK && range_err) ?
		div_pkg::DIV_OVERFLOW : in_op.status;

	always_comb begin
		rsp_next.status = status;
		case (status)
			div_pkg::DIV_ZERO: begin
				rsp_next.quotient  = '1;
				rsp_next.remainder = in_op.dividend_lo;
			end
			div_pkg::DIV_OVERFLOW: begin
				rsp_next.quotient  = '1;
				rsp_next.remainder = '0;
			end
			default: begin
				rsp_next.quotient  = q_fixed;
				rsp_next.remainder = r_fixed;
			end
		endcase
	end

	// The whole pipeline moves when the output slot is free or being read.
	assign advance = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (advance)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (advance)
			out_rsp <= rsp_next;  // Held stable while stalled.
	end

endmodule

// ==== verilog/div_unit_top.sv ====
/* Pipelined divide unit */

`timescale 1ns/1ns

module div_unit_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	output logic              in_ready,
	input  div_pkg::div_req_t in_req,
	output logic              out_valid,
	input  logic              out_ready,
	output div_pkg::div_rsp_t out_rsp
);

	logic             advance;
	logic             dec_valid;
	div_pkg::div_op_t dec_op;
	logic             exe_valid;
	div_pkg::div_op_t exe_op;

	// One global stall, so a request is taken whenever the pipe moves.
	assign in_ready = advance;

	div_decode u_decode (
		.clk      (clk),
		.rst_n    (rst_n),
		.advance  (advance),
		.in_valid (in_valid),
		.in_req   (in_req),
		.op_valid (dec_valid),
		.op       (dec_op)
	);

	div_execute u_execute (
		.clk       (clk),
		.rst_n     (rst_n),
		.advance   (advance),
		.in_valid  (dec_valid),
		.in_op     (dec_op),
		.out_valid (exe_valid),
		.out_op    (exe_op)
	);

	div_result u_result (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (exe_valid),
		.in_op     (exe_op),
		.advance   (advance),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_rsp   (out_rsp)
	);

endmodule

// ==== verification/div_vectors.svh ====
/* Directed divide vectors */

`ifndef DIV_VECTORS_SVH
`define DIV_VECTORS_SVH

// Columns: dividend, divisor, is_signed, then expected quotient, remainder, status.
localparam int NUM_VECTORS = 18;

localparam vector_t VECTORS [NUM_VECTORS] = '{
	'{'{32'd1000, 16'd7, 1'b0}, '{16'd142, 16'd6, div_pkg::DIV_OK}},
	'{'{32'd100, 16'd7, 1'b1}, '{16'd14, 16'd2, div_pkg::DIV_OK}},
	'{'{32'hFFFF_FF9C, 16'd7, 1'b1}, '{16'hFFF2, 16'hFFFE, div_pkg::DIV_OK}},
	'{'{32'd100, 16'hFFF9, 1'b1}, '{16'hFFF2, 16'd2, div_pkg::DIV_OK}},
	'{'{32'hFFFF_FF9C, 16'hFFF9, 1'b1}, '{16'd14, 16'hFFFE, div_pkg::DIV_OK}},
	'{'{32'd7, 16'hFFFE, 1'b1}, '{16'hFFFD, 16'd1, div_pkg::DIV_OK}},
	'{'{32'd0, 16'd5, 1'b0}, '{16'd0, 16'd0, div_pkg::DIV_OK}},
	'{'{32'h0006_FFFF, 16'd7, 1'b0}, '{16'hFFFF, 16'd6, div_pkg::DIV_OK}},
	'{'{32'hFFFE_FFFF, 16'hFFFF, 1'b0}, '{16'hFFFF, 16'hFFFE, div_pkg::DIV_OK}},
	'{'{32'h1234_5678, 16'd0, 1'b0}, '{16'hFFFF, 16'h5678, div_pkg::DIV_ZERO}},
	'{'{32'hFFFF_FF9C, 16'd0, 1'b1}, '{16'hFFFF, 16'hFF9C, div_pkg::DIV_ZERO}},
	'{'{32'h0007_0000, 16'd7, 1'b0}, '{16'hFFFF, 16'd0, div_pkg::DIV_OVERFLOW}},
	'{'{32'hFFFF_FFFF, 16'hFFFF, 1'b0}, '{16'hFFFF, 16'd0, div_pkg::DIV_OVERFLOW}},
	'{'{32'h0000_8000, 16'd1, 1'b1}, '{16'hFFFF, 16'd0, div_pkg::DIV_OVERFLOW}},
	'{'{32'hFFFF_8000, 16'd1, 1'b1}, '{16'h8000, 16'd0, div_pkg::DIV_OK}},
	'{'{32'hFFFF_7FFF, 16'd1, 1'b1}, '{16'hFFFF, 16'd0, div_pkg::DIV_OVERFLOW}},
	'{'{32'h0000_8000, 16'hFFFF, 1'b1}, '{16'h8000, 16'd0, div_pkg::DIV_OK}},
	'{'{32'h8000_0000, 16'hFFFF, 1'b1}, '{16'hFFFF, 16'd0, div_pkg::DIV_OVERFLOW}}
};

`endif

// ==== verification/div_unit_tb.sv ====
/* Divide unit testbench */

`timescale 1ns/1ns

module div_unit_tb;

	typedef struct packed {
		div_pkg::div_req_t req;
		div_pkg::div_rsp_t rsp;
	} vector_t;

	`include "div_vectors.svh"

	localparam int NUM_RANDOM     = 200;
	localparam int NUM_TOTAL      = NUM_VECTORS + NUM_RANDOM;
	localparam int TIMEOUT_CYCLES = 4 * NUM_TOTAL + 100;
	localparam int PIPE_LATENCY   = 10;  // Decode, eight digit stages, result.

	logic              clk;
	logic              rst_n;
	logic              in_valid;
	logic              in_ready;
	div_pkg::div_req_t in_req;
	logic              out_valid;
	logic              out_ready;
	div_pkg::div_rsp_t out_rsp;

	integer            seed;
	int                cycle_count = 0;
	int                error_count = 0;
	int                rsp_count = 0;
	int                accepted_count = 0;
	int                first_accept_cycle = 0;
	bit                seen_output = 0;
	vector_t           expected_q [$];
	vector_t           expected;
	div_pkg::dividend_t rebuilt;

	div_unit_top div_unit_top_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_req    (in_req),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_rsp   (out_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_quotient(div_pkg::quotient_t actual, div_pkg::quotient_t exp_val);
		if (actual !== exp_val) begin
			$display("CHECK FAILED @ %0t: response %0d quotient %h, expected %h",
				$time, rsp_count, actual, exp_val);
			error_count++;
		end
	endtask

	task automatic check_remainder(div_pkg::remainder_t actual, div_pkg::remainder_t exp_val);
		if (actual !== exp_val) begin
			$display("CHECK FAILED @ %0t: response %0d remainder %h, expected %h",
				$time, rsp_count, actual, exp_val);
			error_count++;
		end
	endtask

	task automatic check_status(div_pkg::div_status_t actual, div_pkg::div_status_t exp_val);
		if (actual !== exp_val) begin
			$display("CHECK FAILED @ %0t: response %0d status %s, expected %s",
				$time, rsp_count, actual.name(), exp_val.name());
			error_count++;
		end
	endtask

	task automatic check_dividend(div_pkg::dividend_t actual, div_pkg::dividend_t exp_val);
		if (actual !== exp_val) begin
			$display("CHECK FAILED @ %0t: response %0d rebuilt dividend %h, expected %h",
				$time, rsp_count, actual, exp_val);
			error_count++;
		end
	endtask

	task automatic check_latency(int actual, int exp_val);
		if (actual != exp_val) begin
			$display("CHECK FAILED @ %0t: first response after %0d cycles, expected %0d",
				$time, actual, exp_val);
			error_count++;
		end
	endtask

	// Reference model. A quotient outside the result range is an overflow.
	function automatic div_pkg::div_rsp_t model_divide(div_pkg::div_req_t req);
		logic               dvd_neg;
		logic               dvs_neg;
		logic [31:0]        dvd_mag;
		logic [31:0]        dvs_mag;
		logic [31:0]        q_mag;
		logic [31:0]        r_mag;
		logic [31:0]        q_limit;
		div_pkg::div_rsp_t  rsp;
		dvd_neg = req.is_signed && req.dividend[31];
		dvs_neg = req.is_signed && req.divisor[15];
		dvd_mag = dvd_neg ? -req.dividend : req.dividend;
		dvs_mag = {16'd0, dvs_neg ? -req.divisor : req.divisor};
		rsp.quotient  = '1;
		rsp.remainder = '0;
		if (req.divisor == '0) begin
			rsp.status    = div_pkg::DIV_ZERO;
			rsp.remainder = req.dividend[15:0];
		end else begin
			q_mag   = dvd_mag / dvs_mag;
			r_mag   = dvd_mag % dvs_mag;
			q_limit = !req.is_signed ? 32'd65535 : ((dvd_neg ^ dvs_neg) ? 32'd32768 : 32'd32767);
			rsp.status = (q_mag > q_limit) ? div_pkg::DIV_OVERFLOW : div_pkg::DIV_OK;
			if (rsp.status == div_pkg::DIV_OK) begin
				rsp.quotient  = (dvd_neg ^ dvs_neg) ? -q_mag[15:0] : q_mag[15:0];
				rsp.remainder = dvd_neg ? -r_mag[15:0] : r_mag[15:0];  // Sign of the dividend.
			end
		end
		return rsp;
	endfunction

	// Holds in_valid until the DUT takes the request; out_ready toggles when asked.
	task automatic send_request(vector_t v, bit random_ready);
		logic [31:0] rnd;
		in_valid <= 1'b1;
		in_req   <= v.req;
		do begin
			@(posedge clk);
			rnd = $random(seed);
			if (random_ready)
				out_ready <= rnd[0];
		end while (!in_ready);
		if (accepted_count == 0)
			first_accept_cycle = cycle_count;
		accepted_count++;
		expected_q.push_back(v);
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (rst_n) begin
			if (out_valid && !out_ready && in_ready) begin
				$display("CHECK FAILED @ %0t: in_ready high while output stalled", $time);
				error_count++;
			end
			if (out_valid && !seen_output) begin
				seen_output = 1'b1;
				check_latency(cycle_count - first_accept_cycle, PIPE_LATENCY);
			end
			if (out_valid && out_ready) begin
				if (expected_q.size() == 0) begin
					$display("ERROR @ %0t: a response arrived with no request outstanding", $time);
					error_count++;
				end else begin
					expected = expected_q.pop_front();
					check_quotient(out_rsp.quotient, expected.rsp.quotient);
					check_remainder(out_rsp.remainder, expected.rsp.remainder);
					check_status(out_rsp.status, expected.rsp.status);
					if (!expected.req.is_signed && expected.rsp.status == div_pkg::DIV_OK) begin
						rebuilt = div_pkg::dividend_t'(out_rsp.quotient) *
							div_pkg::dividend_t'(expected.req.divisor) +
							div_pkg::dividend_t'(out_rsp.remainder);
						check_dividend(rebuilt, expected.req.dividend);
					end
				end
				rsp_count++;
			end
		end
	end

	initial begin : watchdog
		while (cycle_count < TIMEOUT_CYCLES)
			@(posedge clk);
		$display("ERROR: timeout after %0d cycles, responses stopped arriving", cycle_count);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		vector_t     v;
		logic [31:0] rnd;
		seed      = 95588;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_req    = '0;
		out_ready = 1'b1;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		// Directed table with out_ready held high.
		for (int i = 0; i < NUM_VECTORS; i++)
			send_request(VECTORS[i], 1'b0);

		for (int i = 0; i < NUM_RANDOM; i++) begin
			rnd              = $random(seed);
			v.req.dividend   = $random(seed);
			v.req.divisor    = 16'($random(seed));
			v.req.is_signed  = rnd[3];
			if (rnd[2:0] == 3'd0)
				v.req.divisor = '0;
			else if (rnd[2:0] < 3'd5)
				v.req.dividend = {{12{v.req.dividend[19]}}, v.req.dividend[19:0]};  // Mostly in range.
			v.rsp = model_divide(v.req);
			send_request(v, 1'b1);
		end
		in_valid <= 1'b0;

		while (expected_q.size() != 0) begin
			@(posedge clk);
			rnd = $random(seed);
			out_ready <= rnd[0];
		end
		out_ready <= 1'b1;
		repeat (20) @(posedge clk);  // Catches any extra response.

		if (rsp_count != NUM_TOTAL)
			$display("ERROR: %0d responses for %0d requests", rsp_count, NUM_TOTAL);
		$display("Done: %0d errors in %0d responses", error_count, rsp_count);
		if (error_count == 0 && rsp_count == NUM_TOTAL) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+verilog
+incdir+verification
verilog/div_pkg.sv
verilog/div_decode.sv
verilog/div_digit_stage.sv
verilog/div_execute.sv
verilog/div_result.sv
verilog/div_unit_top.sv
verification/div_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the divide unit testbench with Verilator, runs it and checks the log.

rm -f sim.log

verilator --binary --timing --top-module div_unit_tb -f verilog.f -o div_unit_sim \
	&& ./obj_dir/div_unit_sim > sim.log 2>&1 \
	|| echo "Build or simulation returned an error"

cat sim.log 2>/dev/null

grep -qF "*** TEST PASSED ***" sim.log && exit 0 || exit 1
